// ==== src/cnnCfg.svh ====
`ifndef CNN_CFG_SVH
`define CNN_CFG_SVH

//--------tile geometry--------
`define CNN_TILE_DIM    8       // side of the square tile
`define CNN_TILE_WORDS  64      // pixels per tile
`define CNN_ADDR_W      6       // pixel address bits

//--------data widths--------
`define CNN_PIX_W       8       // unsigned pixel
`define CNN_WEIGHT_W    4       // signed kernel tap
`define CNN_CONV_W      14      // signed conv output
`define CNN_SUM_W       20      // per layer accumulator
`define CNN_RESULT_W    24      // classifier output

//--------network--------
`define CNN_LAYERS      4       // kernels run per image

`endif

// ==== src/cnnPkg.sv ====
`include "cnnCfg.svh"

package cnnPkg;

    //--------control--------
    typedef enum logic [1:0] {
        IDLE,       // waiting for start
        CONV,       // kernels running
        CLASSIFY,   // fc step issued
        FINISH      // waiting for the result
    } seqState_t;

    // kernel select, also the slot of the average register
    typedef enum logic [1:0] {
        KERNEL_BOX,
        KERNEL_VEDGE,
        KERNEL_HEDGE,
        KERNEL_CENTER
    } kernelOp_t;

    //--------data--------
    // tap k = row * 3 + col, tap 0 is the top left corner
    typedef logic [8:0][`CNN_WEIGHT_W-1:0] kernelWeights_t;

    typedef logic signed [`CNN_CONV_W-1:0] convPixel_t;  // one conv output
    typedef logic signed [`CNN_CONV_W-1:0] average_t;    // pooled plane

endpackage

// ==== src/layerSequencer.sv ====
`timescale 1ns/1ps
`include "cnnCfg.svh"

module layerSequencer (
    input  logic                   i_clk,
    input  logic                   i_rstN,
    input  logic                   i_start,
    input  logic                   i_layerDone,
    input  logic                   i_resultDone,
    output logic                   o_busy,
    output logic                   o_convStart,
    output cnnPkg::kernelOp_t      o_opcode,
    output cnnPkg::kernelWeights_t o_weights,
    output logic                   o_classify
);

    localparam logic [`CNN_WEIGHT_W-1:0] W_ZERO = '0;
    localparam logic [`CNN_WEIGHT_W-1:0] W_ONE  = `CNN_WEIGHT_W'(1);
    localparam logic [`CNN_WEIGHT_W-1:0] W_TWO  = `CNN_WEIGHT_W'(2);
    localparam logic [`CNN_WEIGHT_W-1:0] W_NEG  = {`CNN_WEIGHT_W{1'b1}};  // -1

    cnnPkg::seqState_t state;

    //--------layer fsm--------
    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            state       <= cnnPkg::IDLE;
            o_opcode    <= cnnPkg::KERNEL_BOX;
            o_convStart <= 1'b0;
        end else begin
            o_convStart <= 1'b0;  // single cycle pulse
            case (state)
                cnnPkg::IDLE: begin
                    if (i_start) begin
                        state       <= cnnPkg::CONV;
                        o_opcode    <= cnnPkg::KERNEL_BOX;  // first kernel
                        o_convStart <= 1'b1;
                    end
                end
                cnnPkg::CONV: begin
                    if (i_layerDone) begin
                        if (o_opcode == cnnPkg::kernelOp_t'(`CNN_LAYERS - 1)) begin
                            state <= cnnPkg::CLASSIFY;  // all planes pooled
                        end else begin
                            o_opcode    <= cnnPkg::kernelOp_t'(o_opcode + 2'd1);
                            o_convStart <= 1'b1;
                        end
                    end
                end
                cnnPkg::CLASSIFY: state <= cnnPkg::FINISH;
                cnnPkg::FINISH: begin
                    if (i_resultDone) begin
                        state <= cnnPkg::IDLE;
                    end
                end
                default: state <= cnnPkg::IDLE;
            endcase
        end
    end

    assign o_busy     = (state != cnnPkg::IDLE);
    assign o_classify = (state == cnnPkg::CLASSIFY);  // one cycle in this state

    //--------weight decode--------
    always_comb begin
        for (int k = 0; k < 9; k++) begin
            case (o_opcode)
                cnnPkg::KERNEL_BOX:    o_weights[k] = W_ONE;
                cnnPkg::KERNEL_VEDGE:  o_weights[k] = (k % 3 == 0) ? W_NEG :
                                                      (k % 3 == 2) ? W_ONE : W_ZERO;
                cnnPkg::KERNEL_HEDGE:  o_weights[k] = (k < 3) ? W_NEG :
                                                      (k > 5) ? W_ONE : W_ZERO;
                default:               o_weights[k] = (k == 4) ? W_TWO : W_ZERO;
            endcase
        end
    end

    // a layer start and the fc step never overlap
    assert property (@(posedge i_clk) disable iff (!i_rstN)
        !(o_convStart && o_classify))
        else $error("convStart and classify high together");

endmodule

// ==== src/tileBuffer.sv ====
`timescale 1ns/1ps
`include "cnnCfg.svh"

module tileBuffer (
    input  logic                   i_clk,
    input  logic                   i_locked,
    input  logic                   i_wrEn,
    input  logic [`CNN_ADDR_W-1:0] i_wrAddr,
    input  logic [`CNN_PIX_W-1:0]  i_wrData,
    input  logic [`CNN_ADDR_W-1:0] i_rdAddr,
    output logic [`CNN_PIX_W-1:0]  o_rdData
);

    logic [`CNN_PIX_W-1:0] mem [`CNN_TILE_WORDS];

    //--------host write--------
    always_ff @(posedge i_clk) begin
        if (i_wrEn) begin
            mem[i_wrAddr] <= i_wrData;
        end
    end

    //--------engine read--------
    always_ff @(posedge i_clk) begin
        o_rdData <= mem[i_rdAddr];  // data one cycle after address
    end

    // host must keep out while a run is in progress
    assert property (@(posedge i_clk) !(i_wrEn && i_locked))
        else $error("tile write while engine busy");

endmodule

// ==== src/convEngine.sv ====
`timescale 1ns/1ps
`include "cnnCfg.svh"

module convEngine (
    input  logic                   i_clk,
    input  logic                   i_rstN,
    input  logic                   i_start,
    input  cnnPkg::kernelWeights_t i_weights,
    input  logic [`CNN_PIX_W-1:0]  i_rdData,
    output logic [`CNN_ADDR_W-1:0] o_rdAddr,
    output logic                   o_pixelValid,
    output cnnPkg::convPixel_t     o_pixel,
    output logic                   o_layerDone
);

    localparam int DIM_W = `CNN_ADDR_W / 2;  // row or column bits
    localparam int WIN_W = DIM_W + 2;        // room for -1 and +1 offsets

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_TAP,   // one tap address per cycle
        ENG_ACC,   // last tap lands
        ENG_EMIT   // pixel out
    } engState_t;

    engState_t                      state;
    logic [DIM_W-1:0]               row;
    logic [DIM_W-1:0]               col;
    logic [3:0]                     tap;
    logic [1:0]                     tapR;
    logic [1:0]                     tapC;
    logic [WIN_W-1:0]               winRow;
    logic [WIN_W-1:0]               winCol;
    logic                           inTile;
    logic                           lastPixel;
    logic                           tapValidD;
    logic                           tapInD;
    logic signed [`CNN_WEIGHT_W-1:0] tapWeightD;
    logic signed [`CNN_CONV_W-1:0]  product;
    cnnPkg::convPixel_t             acc;
    logic                           doneDly;

    //--------window position--------
    always_comb begin
        if (tap < 4'd3) begin
            tapR = 2'd0;
            tapC = tap[1:0];
        end else if (tap < 4'd6) begin
            tapR = 2'd1;
            tapC = 2'(tap - 4'd3);
        end else begin
            tapR = 2'd2;
            tapC = 2'(tap - 4'd6);
        end
    end

    // underflow wraps high so one compare covers both borders
    assign winRow = WIN_W'(row) + WIN_W'(tapR) - WIN_W'(1);
    assign winCol = WIN_W'(col) + WIN_W'(tapC) - WIN_W'(1);
    assign inTile = (winRow < WIN_W'(`CNN_TILE_DIM)) && (winCol < WIN_W'(`CNN_TILE_DIM));

    assign o_rdAddr  = {winRow[DIM_W-1:0], winCol[DIM_W-1:0]};
    assign lastPixel = (row == DIM_W'(`CNN_TILE_DIM - 1)) && (col == DIM_W'(`CNN_TILE_DIM - 1));

    //--------tap pipeline--------
    always_ff @(posedge i_clk) begin
        tapInD     <= inTile;          // padding flag follows the read
        tapWeightD <= i_weights[tap];
        if (state == ENG_EMIT) begin
            o_pixel <= acc;
        end
    end

    assign product = $signed({1'b0, i_rdData}) * tapWeightD;

    //--------walk and accumulate--------
    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            state        <= ENG_IDLE;
            row          <= '0;
            col          <= '0;
            tap          <= '0;
            tapValidD    <= 1'b0;
            acc          <= '0;
            o_pixelValid <= 1'b0;
            doneDly      <= 1'b0;
            o_layerDone  <= 1'b0;
        end else begin
            o_pixelValid <= 1'b0;
            doneDly      <= 1'b0;
            o_layerDone  <= doneDly;  // after the last pixel pulse
            tapValidD    <= (state == ENG_TAP);
            if (tapValidD && tapInD) begin
                acc <= acc + product;  // out of tile taps add nothing
            end
            case (state)
                ENG_IDLE: begin
                    if (i_start) begin
                        state <= ENG_TAP;
                        row   <= '0;
                        col   <= '0;
                        tap   <= '0;
                        acc   <= '0;
                    end
                end
                ENG_TAP: begin
                    if (tap == 4'd8) begin
                        tap   <= '0;
                        state <= ENG_ACC;
                    end else begin
                        tap <= tap + 4'd1;
                    end
                end
                ENG_ACC: state <= ENG_EMIT;
                ENG_EMIT: begin
                    o_pixelValid <= 1'b1;
                    acc          <= '0;
                    col          <= col + DIM_W'(1);
                    if (col == DIM_W'(`CNN_TILE_DIM - 1)) begin
                        row <= row + DIM_W'(1);  // raster order
                    end
                    if (lastPixel) begin
                        state   <= ENG_IDLE;
                        doneDly <= 1'b1;
                    end else begin
                        state <= ENG_TAP;
                    end
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    assert property (@(posedge i_clk) disable iff (!i_rstN) tap < 4'd9)
        else $error("tap counter out of range");

endmodule

// ==== src/poolClassifier.sv ====
`timescale 1ns/1ps
`include "cnnCfg.svh"

module poolClassifier (
    input  logic                            i_clk,
    input  logic                            i_rstN,
    input  cnnPkg::kernelOp_t               i_opcode,
    input  logic                            i_pixelValid,
    input  cnnPkg::convPixel_t              i_pixel,
    input  logic                            i_layerDone,
    input  logic                            i_classify,
    output logic signed [`CNN_RESULT_W-1:0] o_result,
    output logic                            o_led,
    output logic                            o_resultDone
);

    localparam int POOL_SHIFT = $clog2(`CNN_TILE_WORDS);  // divide by pixel count

    cnnPkg::average_t                avgReg [`CNN_LAYERS];
    logic signed [`CNN_SUM_W-1:0]    layerSum;
    logic signed [`CNN_RESULT_W-1:0] macAcc;
    logic signed [`CNN_RESULT_W-1:0] macTerm;
    logic signed [`CNN_RESULT_W-1:0] macSum;
    logic                            macActive;
    cnnPkg::kernelOp_t               macSel;

    // fc weight per slot
    function automatic logic signed [`CNN_WEIGHT_W-1:0] fcWeight(input cnnPkg::kernelOp_t op);
        case (op)
            cnnPkg::KERNEL_BOX:   return `CNN_WEIGHT_W'(1);
            cnnPkg::KERNEL_VEDGE: return `CNN_WEIGHT_W'(2);
            cnnPkg::KERNEL_HEDGE: return -`CNN_WEIGHT_W'(3);
            default:              return -`CNN_WEIGHT_W'(1);
        endcase
    endfunction

    //--------average pooling--------
    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            layerSum <= '0;
        end else if (i_layerDone) begin
            layerSum <= '0;  // ready for the next plane
        end else if (i_pixelValid) begin
            layerSum <= layerSum + i_pixel;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_layerDone) begin
            avgReg[i_opcode] <= cnnPkg::average_t'(layerSum >>> POOL_SHIFT);
        end
    end

    //--------fully connected--------
    assign macTerm = avgReg[macSel] * fcWeight(macSel);
    assign macSum  = macAcc + macTerm;

    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            macActive    <= 1'b0;
            macSel       <= cnnPkg::KERNEL_BOX;
            macAcc       <= '0;
            o_result     <= '0;
            o_led        <= 1'b0;
            o_resultDone <= 1'b0;
        end else begin
            o_resultDone <= 1'b0;
            if (i_classify && !macActive) begin
                macActive <= 1'b1;
                macSel    <= cnnPkg::KERNEL_BOX;
                macAcc    <= '0;
            end else if (macActive) begin
                macAcc <= macSum;  // one slot per cycle
                macSel <= cnnPkg::kernelOp_t'(macSel + 2'd1);
                if (macSel == cnnPkg::kernelOp_t'(`CNN_LAYERS - 1)) begin
                    macActive    <= 1'b0;
                    o_result     <= macSum;
                    o_led        <= macSum[`CNN_RESULT_W-1];  // sign as activation
                    o_resultDone <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== src/cnnTop.sv ====
`timescale 1ns/1ps
`include "cnnCfg.svh"

module cnnTop (
    input  logic                            i_clk,
    input  logic                            i_rstN,
    input  logic                            i_wrEn,
    input  logic [`CNN_ADDR_W-1:0]          i_wrAddr,
    input  logic [`CNN_PIX_W-1:0]           i_wrData,
    input  logic                            i_start,
    output logic                            o_busy,
    output logic                            o_done,
    output logic signed [`CNN_RESULT_W-1:0] o_result,
    output logic                            o_led
);

    //--------decode--------
    logic                   convStart;
    logic                   classify;
    logic                   layerDone;
    cnnPkg::kernelOp_t      opcode;
    cnnPkg::kernelWeights_t weights;

    layerSequencer sequencerBlock (
        .i_clk(i_clk),
        .i_rstN(i_rstN),
        .i_start(i_start),
        .i_layerDone(layerDone),
        .i_resultDone(o_done),
        .o_busy(o_busy),
        .o_convStart(convStart),
        .o_opcode(opcode),
        .o_weights(weights),
        .o_classify(classify)
    );

    //--------execute--------
    logic [`CNN_ADDR_W-1:0] rdAddr;
    logic [`CNN_PIX_W-1:0]  rdData;
    logic                   pixelValid;
    cnnPkg::convPixel_t     pixel;

    tileBuffer tileBufferBlock (
        .i_clk(i_clk),
        .i_locked(o_busy),  // host writes only while idle
        .i_wrEn(i_wrEn),
        .i_wrAddr(i_wrAddr),
        .i_wrData(i_wrData),
        .i_rdAddr(rdAddr),
        .o_rdData(rdData)
    );

    convEngine convEngineBlock (
        .i_clk(i_clk),
        .i_rstN(i_rstN),
        .i_start(convStart),
        .i_weights(weights),
        .i_rdData(rdData),
        .o_rdAddr(rdAddr),
        .o_pixelValid(pixelValid),
        .o_pixel(pixel),
        .o_layerDone(layerDone)
    );

    //--------result--------
    poolClassifier poolClassifierBlock (
        .i_clk(i_clk),
        .i_rstN(i_rstN),
        .i_opcode(opcode),
        .i_pixelValid(pixelValid),
        .i_pixel(pixel),
        .i_layerDone(layerDone),
        .i_classify(classify),
        .o_result(o_result),
        .o_led(o_led),
        .o_resultDone(o_done)
    );

endmodule

// ==== sim/cnnTb.sv ====
`timescale 1ns/1ps
`include "cnnCfg.svh"

module cnnTb;

    localparam int RUNS       = 8;     // images started in this test
    localparam int RUN_CYCLES = 3000;  // budget per image incl. tile load
    localparam int FC_W [4]   = '{1, 2, -3, -1};

    logic                            i_clk;
    logic                            i_rstN;
    logic                            i_wrEn;
    logic [`CNN_ADDR_W-1:0]          i_wrAddr;
    logic [`CNN_PIX_W-1:0]           i_wrData;
    logic                            i_start;
    logic                            o_busy;
    logic                            o_done;
    logic signed [`CNN_RESULT_W-1:0] o_result;
    logic                            o_led;

    logic [`CNN_PIX_W-1:0]           tile [`CNN_TILE_WORDS];  // host copy of the tile
    logic signed [`CNN_RESULT_W-1:0] expResult;
    logic signed [`CNN_RESULT_W-1:0] heldResult;
    logic                            heldLed;
    string                           testName;
    int                              seed = 98261;
    int                              acceptedCount = 0;
    int                              doneCount = 0;

    cnnTop dut_i (
        .i_clk(i_clk),
        .i_rstN(i_rstN),
        .i_wrEn(i_wrEn),
        .i_wrAddr(i_wrAddr),
        .i_wrData(i_wrData),
        .i_start(i_start),
        .o_busy(o_busy),
        .o_done(o_done),
        .o_result(o_result),
        .o_led(o_led)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    //--------reference model--------
    function automatic int kernelTap(input int k, input int dr, input int dc);
        case (k)
            0:       return 1;   // box
            1:       return dc;  // vertical edge, -1 0 1 per row
            2:       return dr;  // horizontal edge, -1 0 1 per column
            default: return (dr == 0 && dc == 0) ? 2 : 0;
        endcase
    endfunction

    function automatic logic signed [`CNN_RESULT_W-1:0] modelResult();
        int sum;
        int rr;
        int cc;
        int res;
        res = 0;
        for (int k = 0; k < `CNN_LAYERS; k++) begin
            sum = 0;
            for (int p = 0; p < `CNN_TILE_WORDS; p++) begin
                for (int dr = -1; dr <= 1; dr++) begin
                    for (int dc = -1; dc <= 1; dc++) begin
                        rr = p / `CNN_TILE_DIM + dr;
                        cc = p % `CNN_TILE_DIM + dc;
                        if (rr >= 0 && rr < `CNN_TILE_DIM && cc >= 0 && cc < `CNN_TILE_DIM) begin
                            sum += int'(tile[rr * `CNN_TILE_DIM + cc]) * kernelTap(k, dr, dc);
                        end  // border taps are zero
                    end
                end
            end
            res += (sum >>> 6) * FC_W[k];  // floor average of the plane
        end
        return res[`CNN_RESULT_W-1:0];
    endfunction

    //--------checks--------
    task automatic reportFailure(input string name, input int expected, input int actual);
        $display("FAILED %s expected %0d actual %0d", name, expected, actual);
        $display("test failed");
        $fatal(1, "check %s did not hold", name);
    endtask

    always @(posedge i_clk) begin
        if (i_rstN && i_start && !o_busy) acceptedCount <= acceptedCount + 1;
        if (i_rstN && o_done) doneCount <= doneCount + 1;
    end

    always @(negedge i_clk) begin
        if (!i_rstN) begin
            heldResult = '0;
            heldLed    = 1'b0;
        end else if (o_done) begin
            heldResult = o_result;  // value that must hold until the next done
            heldLed    = o_led;
        end
    end

    assert property (@(posedge i_clk) !i_rstN |=>
        (!o_busy && !o_done && !o_led && o_result == 0))
        else reportFailure("reset", 0, int'({o_busy, o_done, o_led, o_result != 0}));

    assert property (@(posedge i_clk) disable iff (!i_rstN) o_done |-> o_result == expResult)
        else reportFailure(testName, expResult, o_result);

    assert property (@(posedge i_clk) disable iff (!i_rstN) o_done |-> o_led == expResult[23])
        else reportFailure({testName, " led"}, int'(expResult[23]), int'(o_led));

    assert property (@(posedge i_clk) disable iff (!i_rstN)
        !o_done |-> (o_result == heldResult && o_led == heldLed))
        else reportFailure({testName, " hold"}, heldResult, o_result);

    assert property (@(posedge i_clk) disable iff (!i_rstN)
        o_done |-> (o_busy && dut_i.sequencerBlock.state == cnnPkg::FINISH))
        else reportFailure("done in FINISH", int'(cnnPkg::FINISH),
                           int'(dut_i.sequencerBlock.state));

    assert property (@(posedge i_clk) disable iff (!i_rstN)
        o_done |-> acceptedCount == doneCount + 1)
        else reportFailure("one done per start", doneCount + 1, acceptedCount);

    //--------stimulus--------
    task automatic writeTile();
        for (int a = 0; a < `CNN_TILE_WORDS; a++) begin
            @(posedge i_clk);
            i_wrEn   <= 1'b1;
            i_wrAddr <= `CNN_ADDR_W'(a);
            i_wrData <= tile[a];
        end
        @(posedge i_clk);
        i_wrEn <= 1'b0;
    endtask

    task automatic pulseStart();
        @(posedge i_clk);
        i_start <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
    endtask

    task automatic waitForDone();
        @(negedge i_clk);
        while (!o_done) @(negedge i_clk);
        while (o_busy) @(negedge i_clk);  // tile is free again
    endtask

    task automatic runImage(input string name, input logic extraStart);
        testName  = name;
        expResult = modelResult();
        writeTile();
        pulseStart();
        if (extraStart) begin
            repeat (30) @(posedge i_clk);
            pulseStart();  // lands while busy
        end
        waitForDone();
    endtask

    // watchdog
    initial begin
        repeat (RUNS * RUN_CYCLES) @(posedge i_clk);
        $display("watchdog expired, the DUT did not finish all runs in time");
        $display("test failed");
        $fatal(1, "timeout");
    end

    initial begin
        i_rstN    = 1'b0;
        i_wrEn    = 1'b0;
        i_wrAddr  = '0;
        i_wrData  = '0;
        i_start   = 1'b0;
        testName  = "reset";
        expResult = '0;
        repeat (5) @(posedge i_clk);
        i_rstN <= 1'b1;

        for (int a = 0; a < `CNN_TILE_WORDS; a++) tile[a] = '0;
        runImage("zero tile", 1'b0);
        for (int a = 0; a < `CNN_TILE_WORDS; a++) tile[a] = 8'd200;
        runImage("constant tile", 1'b0);
        for (int n = 0; n < 3; n++) begin
            for (int a = 0; a < `CNN_TILE_WORDS; a++) tile[a] = 8'($random(seed));
            runImage($sformatf("random tile %0d", n), 1'b0);
        end
        for (int a = 0; a < `CNN_TILE_WORDS; a++) tile[a] = 8'($random(seed));
        runImage("start while busy", 1'b1);

        // reload after done
        for (int a = 0; a < `CNN_TILE_WORDS; a++) begin
            tile[a] = (a >= `CNN_TILE_WORDS - `CNN_TILE_DIM) ? 8'd255 : 8'd0;  // bottom row only
        end
        runImage("reload bottom row", 1'b0);  // negative result, led high
        for (int a = 0; a < `CNN_TILE_WORDS; a++) tile[a] = '0;
        runImage("reload zero", 1'b0);

        if (doneCount != RUNS) begin
            reportFailure("done count", RUNS, doneCount);
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

// ==== sim.f ====
+incdir+src
src/cnnPkg.sv
src/layerSequencer.sv
src/tileBuffer.sv
src/convEngine.sv
src/poolClassifier.sv
src/cnnTop.sv
sim/cnnTb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the cnnTop testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module cnnTb -f sim.f -o simCnn
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/simCnn
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished cleanly"
exit 0
